/* mipsPkg.sv */
package mipsPkg;

    //////////////////////////////
    // Primary opcode
    //////////////////////////////

    // Only the codes the front end cares about
    typedef enum logic [5:0] {
        SPECIAL = 6'b000000,    // Funct field picks the op
        REGIMM  = 6'b000001,    // Rt field picks the op
        J       = 6'b000010,
        JAL     = 6'b000011,
        BEQ     = 6'b000100,    // B when rs and rt are both zero
        BNE     = 6'b000101,
        BLEZ    = 6'b000110,    // Rt must be zero
        BGTZ    = 6'b000111     // Rt must be zero
    } opcodeE;

    //////////////////////////////
    // REGIMM rt field
    //////////////////////////////

    typedef enum logic [4:0] {
        BLTZ   = 5'b00000,
        BGEZ   = 5'b00001,
        BLTZAL = 5'b10000,
        BGEZAL = 5'b10001       // BAL when rs is zero
    } regimmE;

    // SPECIAL function code for JALR
    localparam logic [5:0] FunctJalr = 6'b001001;

    //////////////////////////////
    // Field positions
    //////////////////////////////

    localparam int OpHi    = 31;    // Primary opcode
    localparam int OpLo    = 26;
    localparam int RsHi    = 25;    // Rs ends just above RtHi
    localparam int RtHi    = 20;
    localparam int RtLo    = 16;
    localparam int FunctHi = 5;     // Funct starts at bit 0
    localparam int ImmHi   = 15;    // 16-bit offset, also the sign bit
    localparam int IdxHi   = 25;    // 26-bit jump index

endpackage

/* fetchPkg.sv */
package fetchPkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int QueueDepth = 4;                      // Power of two, pointers wrap
    localparam int QueuePtrW  = $clog2(QueueDepth);
    localparam int RomWords   = 64;
    localparam int RomAddrW   = $clog2(RomWords);       // Word index bits

    localparam logic [31:0] ResetPc = 32'h0000_0000;    // First fetch after reset

    //////////////////////////////
    // Predecode result
    //////////////////////////////

    typedef struct packed {
        logic        isJ;           // Must redirect
        logic        isBr;          // Conditional, backend resolves
        logic        jr;            // No sequential fetch after this one
        logic        needsTarget;   // JALR, target comes from backend
        logic [31:0] target;        // Static target, zero if none
    } predecodeT;

    //////////////////////////////
    // Queue payload
    //////////////////////////////

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        predecodeT   pd;
    } fetchEntryT;

    // Backend redirect request
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirectT;

endpackage

/* predecoder.sv */
`timescale 1ns/1ps

module predecoder import mipsPkg::*, fetchPkg::*; (
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        valid,
    output predecodeT   pd
);

    opcodeE      op;
    regimmE      rtCode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] brTarget;
    logic [31:0] jTarget;

    // Field extraction
    assign op     = opcodeE'(inst[OpHi:OpLo]);
    assign rs     = inst[RsHi:RtHi+1];
    assign rt     = inst[RtHi:RtLo];
    assign rtCode = regimmE'(rt);

    // PC relative, no delay slot so base is the branch itself
    assign brTarget = pc + {{14{inst[ImmHi]}}, inst[ImmHi:0], 2'b00};
    // Region jump, upper PC bits kept
    assign jTarget  = {pc[31:28], inst[IdxHi:0], 2'b00};

    always_comb begin
        pd = '0;                                // Plain word or no response
        if (valid) begin
            case (op)
                J, JAL: begin                   // Quick redirect
                    pd.isJ    = 1'b1;
                    pd.jr     = 1'b1;
                    pd.target = jTarget;
                end
                BEQ: begin
                    pd.target = brTarget;
                    if (rs == '0 && rt == '0) begin
                        pd.isJ = 1'b1;          // B, always taken
                        pd.jr  = 1'b1;
                    end else begin
                        pd.isBr = 1'b1;
                    end
                end
                BNE: begin
                    pd.isBr   = 1'b1;
                    pd.target = brTarget;
                end
                BLEZ, BGTZ: begin
                    if (rt == '0) begin         // Other rt values are not branches
                        pd.isBr   = 1'b1;
                        pd.target = brTarget;
                    end
                end
                REGIMM: begin
                    case (rtCode)
                        BGEZAL: begin
                            pd.target = brTarget;
                            if (rs == '0) begin
                                pd.isJ = 1'b1;  // BAL
                                pd.jr  = 1'b1;
                            end else begin
                                pd.isBr = 1'b1;
                            end
                        end
                        BLTZ, BGEZ, BLTZAL: begin
                            pd.isBr   = 1'b1;
                            pd.target = brTarget;
                        end
                        default: ;              // Traps and the like
                    endcase
                end
                SPECIAL: begin
                    // JALR, target lives in a register
                    if (inst[FunctHi:0] == FunctJalr && rt == '0) begin
                        pd.isJ        = 1'b1;
                        pd.jr         = 1'b1;
                        pd.needsTarget = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* pcGen.sv */
`timescale 1ns/1ps

module pcGen import fetchPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  predecodeT   pd,             // Flags low unless respValid
    input  redirectT    beRedirect,
    input  logic        full,           // Queue has no room for one more word
    output logic [31:0] fetchPc,
    output logic        fetchEn,
    output logic [31:0] respPc,
    output logic        respValid,
    output logic        enq,
    output logic        flush
);

    typedef enum logic {
        FETCH,
        WAITTARGET      // Parked behind a JALR
    } stateE;

    stateE       state;
    stateE       stateNext;
    logic [31:0] pcNext;
    logic        pdRedirect;
    logic        kill;

    assign pdRedirect = pd.isJ && !pd.needsTarget;  // Target known at fetch
    assign kill       = beRedirect.valid || pd.isJ; // Word fetched now is wrong path
    assign fetchEn    = (state == FETCH) && !full;
    assign enq        = respValid && !beRedirect.valid;
    assign flush      = beRedirect.valid;           // Queue never sees redirectT

    //////////////////////////////
    // Next PC, backend first
    //////////////////////////////

    always_comb begin
        pcNext    = fetchPc;
        stateNext = state;
        if (beRedirect.valid) begin
            pcNext    = beRedirect.target;
            stateNext = FETCH;                      // Also releases a JALR wait
        end else if (pdRedirect) begin
            pcNext = pd.target;
        end else if (pd.needsTarget) begin
            stateNext = WAITTARGET;
        end else if (fetchEn) begin
            pcNext = fetchPc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPc   <= ResetPc;
            state     <= FETCH;
            respValid <= 1'b0;
        end else begin
            fetchPc   <= pcNext;
            state     <= stateNext;
            respValid <= fetchEn && !kill;          // One bubble on redirect
        end
    end

    // PC of the word the ROM returns next cycle
    always_ff @(posedge clk) begin
        if (fetchEn) begin
            respPc <= fetchPc;
        end
    end

endmodule

/* instRom.sv */
`timescale 1ns/1ps

module instRom import fetchPkg::*; (
    input  logic        clk,
    input  logic [31:0] addr,       // Byte address
    input  logic        en,
    output logic [31:0] rdata
);

    logic [31:0]         mem [RomWords];
    logic [RomAddrW-1:0] wordIdx;

    // Program image
    initial begin
        $readmemh("prog.hex", mem);
    end

    // Drop byte offset, upper bits wrap inside the ROM
    assign wordIdx = addr[RomAddrW+1:2];

    //////////////////////////////
    // Synchronous read
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[wordIdx];  // Holds last word when idle
        end
    end

endmodule

/* fetchQueue.sv */
`timescale 1ns/1ps

module fetchQueue import fetchPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       enq,
    input  fetchEntryT din,
    input  logic       deq,
    input  logic       flush,
    output fetchEntryT head,
    output logic       headValid,
    output logic       full
);

    fetchEntryT           mem [QueueDepth];
    logic [QueuePtrW-1:0] rdPtr;
    logic [QueuePtrW-1:0] wrPtr;
    logic [QueuePtrW:0]   count;
    logic [QueuePtrW:0]   countNext;
    logic                 doEnq;
    logic                 doDeq;

    assign doEnq = enq && !flush;       // Flush wins over enq
    assign doDeq = deq && headValid;    // Deq on empty is ignored

    assign headValid = (count != '0);
    assign head      = mem[rdPtr];

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    always_comb begin
        countNext = count;
        if (flush) begin
            countNext = '0;
        end else begin
            if (doEnq) begin
                countNext = countNext + (QueuePtrW+1)'(1);
            end
            if (doDeq) begin
                countNext = countNext - (QueuePtrW+1)'(1);
            end
        end
    end

    // Level after this cycle, so a deq now frees a slot
    assign full = (countNext == (QueuePtrW+1)'(QueueDepth));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;                // Drop everything younger
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doEnq) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at depth
            end
            if (doDeq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= countNext;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (doEnq) begin
            mem[wrPtr] <= din;
        end
    end

endmodule

/* frontEnd.sv */
`timescale 1ns/1ps

module frontEnd import fetchPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       deq,         // Decoder takes the head entry
    input  redirectT   beRedirect,
    output fetchEntryT head,
    output logic       headValid,
    output logic       full
);

    logic [31:0] fetchPc;
    logic [31:0] respPc;
    logic [31:0] rdata;
    logic        fetchEn;
    logic        respValid;
    logic        enq;
    logic        flush;
    predecodeT   pd;
    fetchEntryT  entry;

    //////////////////////////////
    // Fetch and predecode
    //////////////////////////////

    pcGen u_pcGen (
        .clk        (clk),
        .arstN      (arstN),
        .pd         (pd),
        .beRedirect (beRedirect),
        .full       (full),
        .fetchPc    (fetchPc),
        .fetchEn    (fetchEn),
        .respPc     (respPc),
        .respValid  (respValid),
        .enq        (enq),
        .flush      (flush)
    );

    instRom u_instRom (
        .clk   (clk),
        .addr  (fetchPc),
        .en    (fetchEn),
        .rdata (rdata)
    );

    predecoder u_predecoder (
        .inst  (rdata),
        .pc    (respPc),
        .valid (respValid),
        .pd    (pd)
    );

    // Response plus its predecode
    assign entry = '{pc: respPc, inst: rdata, pd: pd};

    fetchQueue u_fetchQueue (
        .clk       (clk),
        .arstN     (arstN),
        .enq       (enq),
        .din       (entry),
        .deq       (deq),
        .flush     (flush),
        .head      (head),
        .headValid (headValid),
        .full      (full)
    );

endmodule

/* tbFrontEnd.sv */
`timescale 1ns/1ps

module tbFrontEnd import mipsPkg::*, fetchPkg::*;;

    localparam int NumDeq      = 300;                       // Entries checked
    localparam int ResetCycles = 3;
    localparam int CycleLimit  = 8 * NumDeq + ResetCycles;
    localparam int FillCycles  = 7;                         // Long enough for full to settle
    localparam logic [31:0] FillPc = 32'h0000_00D8;         // Word 54 starts an ALU run

    logic        clk;
    logic        arstN;
    logic        deq;
    redirectT    beRedirect;
    fetchEntryT  head;
    logic        headValid;
    logic        full;

    logic [31:0] progMem [RomWords];        // Own copy of the program
    logic [31:0] lcgState = 32'd9056;
    logic [31:0] expPc;                     // Next PC of the program walk
    logic [31:0] redirectTarget;
    logic        redirectPending;
    logic        jalrWait;                  // Nothing may reach the head
    logic        levelCheck;                // Levels have a known value this cycle
    logic        expHeadValid;
    logic        expFull;
    int          redirectDelay;
    int          deqCount;
    int          cycleCount = 0;
    int          jumpCount;
    int          brCount;
    int          takenCount;
    int          jalrCount;

    frontEnd u_frontEnd (
        .clk        (clk),
        .arstN      (arstN),
        .deq        (deq),
        .beRedirect (beRedirect),
        .head       (head),
        .headValid  (headValid),
        .full       (full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {16'h0000, lcgState[31:16]};     // High bits are the better ones
    endfunction

    function automatic predecodeT refPredecode(input logic [31:0] inst, input logic [31:0] pc);
        predecodeT   p;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] brTarget;
        logic        isAlways;
        logic        isCond;
        p        = '0;
        op       = inst[31:26];
        rs       = inst[25:21];
        rt       = inst[20:16];
        brTarget = pc + 32'($signed(inst[15:0]) * 4);          // Base is the branch
        isAlways = (op == BEQ && rs == 5'd0 && rt == 5'd0)
                || (op == REGIMM && rt == BGEZAL && rs == 5'd0);
        isCond   = (op == BEQ) || (op == BNE)
                || ((op == BLEZ || op == BGTZ) && rt == 5'd0)
                || (op == REGIMM && (rt == BLTZ || rt == BGEZ || rt == BLTZAL || rt == BGEZAL));
        if (op == J || op == JAL) begin
            p.isJ    = 1'b1;
            p.jr     = 1'b1;
            p.target = (pc & 32'hF000_0000) | (32'(inst[25:0]) << 2);
        end else if (isAlways) begin        // B and BAL
            p.isJ    = 1'b1;
            p.jr     = 1'b1;
            p.target = brTarget;
        end else if (isCond) begin
            p.isBr   = 1'b1;
            p.target = brTarget;
        end else if (op == SPECIAL && inst[5:0] == FunctJalr && rt == 5'd0) begin
            p.isJ         = 1'b1;
            p.jr          = 1'b1;
            p.needsTarget = 1'b1;
        end
        return p;
    endfunction

    function automatic logic [31:0] refNext(input logic [31:0] pc, input predecodeT p,
                                            input logic taken, input logic [31:0] beTarget);
        if (p.needsTarget || taken) begin
            return beTarget;                // Backend decides
        end
        if (p.isJ) begin
            return p.target;
        end
        return pc + 32'd4;                  // Not taken or plain
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stopOnError();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkPredecode(input predecodeT got, input predecodeT exp);
        if ({got.isJ, got.isBr, got.jr, got.needsTarget} !==
            {exp.isJ, exp.isBr, exp.jr, exp.needsTarget}) begin
            $display("ERROR %0t head.pd flags got %b expected %b (isJ isBr jr needsTarget)",
                     $time, {got.isJ, got.isBr, got.jr, got.needsTarget},
                     {exp.isJ, exp.isBr, exp.jr, exp.needsTarget});
            stopOnError();
        end else if (got.target !== exp.target) begin
            $display("ERROR %0t head.pd.target got %h expected %h",
                     $time, got.target, exp.target);
            stopOnError();
        end
    endtask

    task automatic checkEntry(input fetchEntryT got, input fetchEntryT exp);
        if (got.pc !== exp.pc) begin
            $display("ERROR %0t head.pc got %h expected %h", $time, got.pc, exp.pc);
            stopOnError();
        end else if (got.inst !== exp.inst) begin
            $display("ERROR %0t head.inst got %h expected %h", $time, got.inst, exp.inst);
            stopOnError();
        end else begin
            checkPredecode(got.pd, exp.pd);
        end
    endtask

    // Head is taken at the coming edge so check it and step the walk
    task automatic takeEntry();
        fetchEntryT  exp;
        logic        taken;
        logic [31:0] beTarget;
        exp.pc   = expPc;
        exp.inst = progMem[expPc[RomAddrW+1:2]];
        exp.pd   = refPredecode(exp.inst, exp.pc);
        checkEntry(head, exp);
        taken    = 1'b0;
        beTarget = '0;
        if (exp.pd.needsTarget) begin
            beTarget        = 32'((lcgNext() % RomWords) * 4);  // Anywhere in the ROM
            redirectDelay   = int'(lcgNext() % 4);
            redirectPending = 1'b1;
            jalrWait        = 1'b1;
            jalrCount       = jalrCount + 1;
        end else if (exp.pd.isBr) begin
            brCount = brCount + 1;
            if (lcgNext() % 3 == 0) begin           // Backend finds it taken
                taken           = 1'b1;
                beTarget        = exp.pd.target;
                redirectDelay   = 0;
                redirectPending = 1'b1;
                takenCount      = takenCount + 1;
            end
        end else if (exp.pd.isJ) begin
            jumpCount = jumpCount + 1;
        end
        redirectTarget = beTarget;
        expPc          = refNext(expPc, exp.pd, taken, beTarget);
        deqCount       = deqCount + 1;
    endtask

    // Compare on the falling edge where inputs and head are settled
    always @(negedge clk) begin
        if (arstN && levelCheck) begin
            checkLevel("headValid", headValid, expHeadValid);
            checkLevel("full", full, expFull);
        end
        if (arstN && jalrWait && headValid) begin
            $display("FAILURE an entry reached the head after JALR before the backend redirect");
            stopOnError();
        end else if (arstN && deq && headValid) begin
            takeEntry();
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            $display("TIMEOUT the front end stalled, %0d of %0d entries after %0d cycles",
                     deqCount, NumDeq, cycleCount);
            stopOnError();
        end
    end

    //////////////////////////////
    // Stimulus and backend
    //////////////////////////////

    initial begin
        arstN           = 1'b0;
        deq             = 1'b0;
        beRedirect      = '0;
        expPc           = ResetPc;
        redirectTarget  = '0;
        redirectPending = 1'b0;
        jalrWait        = 1'b0;
        levelCheck      = 1'b0;
        expHeadValid    = 1'b0;
        expFull         = 1'b0;
        redirectDelay   = 0;
        deqCount        = 0;
        jumpCount       = 0;
        brCount         = 0;
        takenCount      = 0;
        jalrCount       = 0;
        $readmemh("prog.hex", progMem);

        repeat (ResetCycles) @(posedge clk);
        #1 arstN = 1'b1;

        while (deqCount < NumDeq) begin
            @(posedge clk);
            #1;
            if (redirectPending && redirectDelay == 0) begin
                beRedirect.valid  = 1'b1;       // One cycle pulse flushes the queue
                beRedirect.target = redirectTarget;
                deq               = 1'b0;       // Head is wrong path now
                redirectPending   = 1'b0;
                jalrWait          = 1'b0;
            end else begin
                if (redirectPending) begin
                    redirectDelay = redirectDelay - 1;  // Backend still resolving
                end
                beRedirect = '0;
                deq        = (lcgNext() % 3) != 0;      // Gaps let the queue fill
            end
        end

        // Restart on the ALU run with the decoder held off
        beRedirect.valid  = 1'b1;
        beRedirect.target = FillPc;
        deq               = 1'b0;
        redirectPending   = 1'b0;
        jalrWait          = 1'b0;
        expPc             = FillPc;
        for (int i = 1; i <= FillCycles; i++) begin
            @(posedge clk);
            #1;
            beRedirect   = '0;
            levelCheck   = 1'b1;
            expHeadValid = (i >= 3);                    // First word enqueued 2 cycles on
            expFull      = (i >= 2 + QueueDepth - 1);   // Last free slot taken
        end

        // Steady dequeue frees the slot each refill takes
        for (int i = 0; i < QueueDepth; i++) begin
            @(posedge clk);
            #1;
            deq          = 1'b1;
            expHeadValid = 1'b1;
            expFull      = 1'b0;
        end
        @(posedge clk);
        #1;
        deq        = 1'b0;
        levelCheck = 1'b0;

        // Every kind of control flow must have shown up
        if (jumpCount == 0 || brCount == 0 || takenCount == 0 || jalrCount == 0) begin
            $display("FAILURE walk missed a case, jumps %0d branches %0d taken %0d jalr %0d",
                     jumpCount, brCount, takenCount, jalrCount);
            stopOnError();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* frontEnd.f */
mipsPkg.sv
fetchPkg.sv
predecoder.sv
pcGen.sv
instRom.sv
fetchQueue.sv
frontEnd.sv
tbFrontEnd.sv

/* Makefile */
TOP := tbFrontEnd

.PHONY: all lint clean

# Build, run, then decide on the pass line in the output
all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f frontEnd.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f frontEnd.f

clean:
	rm -rf obj_dir

/* prog.hex */
// Instruction words, two per line, in word address order
// Trailing comment gives the word index of the first word and what the pair holds
24010001 24020002   // 0  addiu, addiu
00221821 08000008   // 2  addu, j 8
24040004 24050005   // 4  skipped by the j
24060006 24070007   // 6
3C08ABCD 14220006   // 8  lui, bne +6 to 15
35080001 0C000014   // 10 ori, jal 20
240C000C 240D000D   // 12 skipped by the jal
240E000E 1022FFFD   // 14 beq back to 12
24100010 08000014   // 16 j 20
24120012 24130013   // 18
24140014 18600004   // 20 jal target, blez +4 to 25
1C60FFFE 24170017   // 22 bgtz back to 20
08000020 24190019   // 24 j 32, blez target
241A001A 0480FFF9   // 26 bltz back to 20
08000024 241D001D   // 28 b target, j 36
241E001E 241F001F   // 30
24210020 24220021   // 32
1000FFFA 24230023   // 34 b back to 28, skipped word
24240024 04110005   // 36 bal +5 to 42
24260026 24270027   // 38 skipped by the bal
24280028 24290029   // 40
14A00003 242B002B   // 42 bne +3 to 45
04810002 242D002D   // 44 bgez +2 to 46
04900003 242F002F   // 46 bltzal +3 to 49
04910002 24310031   // 48 bgezal conditional +2 to 50
1C600002 24330033   // 50 bgtz +2 to 52
00A0F809 24350035   // 52 jalr, then words only reached through jalr
24360036 24370037   // 54
24380038 24390039   // 56
243A003A 243B003B   // 58
243C003C 243D003D   // 60
243E003E 08000000   // 62 j back to 0
